// ==== filelist.f ====
rtl/dspTypesPkg.sv
rtl/ncoPkg.sv
rtl/mixerControl.sv
rtl/sinCosTable.sv
rtl/complexMultSat.sv
rtl/digitalMixer.sv
test/mixerTb.sv

// ==== rtl/complexMultSat.sv ====
// Complex multiplier with saturation
`default_nettype none

module complexMultSat
    import dspTypesPkg::*;
(
    input  wire logic   clk,
    input  wire logic   arstN,
    input  wire sampleT aReal,
    input  wire sampleT aImag,
    input  wire sampleT bReal,
    input  wire sampleT bImag,
    output sampleT      pReal,
    output sampleT      pImag
);

    // Registered partial products
    productT prodRxR;
    productT prodIxI;
    productT prodRxI;
    productT prodIxR;

    // Complex sums, one guard bit above bit 34
    productT realSum;
    productT imagSum;

    // Clamp on overflow, else keep bits 34 to 17
    function automatic sampleT saturate(input productT sum);
        if (sum[35] != sum[34]) begin
            return sum[35] ? satNegMax : satPosMax;
        end
        return sum[fracBits +: $bits(sampleT)];
    endfunction

    // Stage one, four products
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            prodRxR <= '0;
            prodIxI <= '0;
            prodRxI <= '0;
            prodIxR <= '0;
        end else begin
            prodRxR <= aReal * bReal;
            prodIxI <= aImag * bImag;
            prodRxI <= aReal * bImag;
            prodIxR <= aImag * bReal;
        end
    end

    // Products re-extended from bit 34
    // Only -1 x -1 uses bit 35, and the table never reaches -1
    assign realSum = {prodRxR[34], prodRxR[34:0]} - {prodIxI[34], prodIxI[34:0]};
    assign imagSum = {prodRxI[34], prodRxI[34:0]} + {prodIxR[34], prodIxR[34:0]};

    // Stage two, saturated outputs
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pReal <= '0;
            pImag <= '0;
        end else begin
            pReal <= saturate(realSum);
            pImag <= saturate(imagSum);
        end
    end

    // Negative clamp is not followed by the code just below it
    realClampStep: assert property (
        @(posedge clk) disable iff (!arstN)
        (pReal == satNegMax) |=> (pReal != sampleT'(satNegMax - 18'sd1))
    ) else $error("real path stepped below negative clamp");

    imagClampStep: assert property (
        @(posedge clk) disable iff (!arstN)
        (pImag == satNegMax) |=> (pImag != sampleT'(satNegMax - 18'sd1))
    ) else $error("imag path stepped below negative clamp");

endmodule : complexMultSat

`default_nettype wire

// ==== rtl/digitalMixer.sv ====
// Digital mixer top level
`default_nettype none

module digitalMixer
    import dspTypesPkg::*;
    import ncoPkg::*;
(
    input  wire logic   clk,
    input  wire logic   arstN,
    input  wire logic   inValid,
    input  wire sampleT inReal,
    input  wire sampleT inImag,
    input  wire logic   freqLoad,
    input  wire phaseT  freqWord,
    input  wire logic   phaseClear,
    output logic        outValid,
    output sampleT      outReal,
    output sampleT      outImag
);

    // Phase address to the table
    tableAddrT tableAddr;

    // Captured sample on the multiplier a side
    sampleT sampleReal;
    sampleT sampleImag;

    // Phasor on the multiplier b side
    sampleT cosVal;
    sampleT sinVal;

    // Oscillator, capture and valid line
    mixerControl control (
        .clk        (clk),
        .arstN      (arstN),
        .inValid    (inValid),
        .freqLoad   (freqLoad),
        .freqWord   (freqWord),
        .phaseClear (phaseClear),
        .inReal     (inReal),
        .inImag     (inImag),
        .tableAddr  (tableAddr),
        .sampleReal (sampleReal),
        .sampleImag (sampleImag),
        .outValid   (outValid)
    );

    // Phase to cosine and sine
    sinCosTable sinCos (
        .tableAddr (tableAddr),
        .cosVal    (cosVal),
        .sinVal    (sinVal)
    );

    // Sample times phasor
    complexMultSat mult (
        .clk   (clk),
        .arstN (arstN),
        .aReal (sampleReal),
        .aImag (sampleImag),
        .bReal (cosVal),
        .bImag (sinVal),
        .pReal (outReal),
        .pImag (outImag)
    );

endmodule : digitalMixer

`default_nettype wire

// ==== rtl/dspTypesPkg.sv ====
// Sample and product types
`default_nettype none

package dspTypesPkg;

    // Signed 18-bit sample, Q1.17
    // Also used for cosine and sine table values
    typedef logic signed [17:0] sampleT;

    // Full-precision 18x18 product
    // Also holds the complex sums before rounding
    typedef logic signed [35:0] productT;

    // Largest positive output, +1 minus one LSB
    localparam sampleT satPosMax = 18'sh1ffff;

    // Negative clamp, mirrors satPosMax
    // Keeps hex 20000 out of the clamped range
    localparam sampleT satNegMax = 18'sh20001;

    // Fraction bits in a sample
    // A product carries twice as many
    localparam int fracBits = 17;

endpackage : dspTypesPkg

`default_nettype wire

// ==== rtl/mixerControl.sv ====
// Mixer oscillator and control
`default_nettype none

module mixerControl
    import dspTypesPkg::*;
    import ncoPkg::*;
(
    input  wire logic      clk,
    input  wire logic      arstN,
    input  wire logic      inValid,
    input  wire logic      freqLoad,
    input  wire phaseT     freqWord,
    input  wire logic      phaseClear,
    input  wire sampleT    inReal,
    input  wire sampleT    inImag,
    output tableAddrT      tableAddr,
    output sampleT         sampleReal,
    output sampleT         sampleImag,
    output logic           outValid
);

    // Control states
    typedef enum logic {
        idle,
        running
    } ctlStateT;

    ctlStateT state;

    // Held tuning word
    phaseT freqReg;

    // Running phase
    phaseT phaseAcc;

    // Captured phase address, goes to the table
    tableAddrT addrReg;

    // Valid bit per pipeline stage
    logic [mixLatency-1:0] validLine;

    // Tuning word register
    // A load in the same cycle as a sample only affects later increments
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            freqReg <= '0;
        end else if (freqLoad) begin
            freqReg <= freqWord;
        end
    end

    // Phase advances once per accepted sample
    // Clear wins over the increment
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phaseAcc <= '0;
        end else if (phaseClear) begin
            phaseAcc <= '0;
        end else if (inValid) begin
            phaseAcc <= phaseAcc + freqReg;
        end
    end

    // Sample and pre-increment phase captured together
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sampleReal <= '0;
            sampleImag <= '0;
            addrReg    <= '0;
        end else if (inValid) begin
            sampleReal <= inReal;
            sampleImag <= inImag;
            addrReg    <= phaseAcc[phaseWidth-1 -: $bits(tableAddrT)];
        end
    end

    // Valid follows the data through capture, product and saturation
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validLine <= '0;
        end else begin
            validLine <= {validLine[mixLatency-2:0], inValid};
        end
    end

    // Leaves idle on the first sample, then stays running
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= idle;
        end else if (state == idle && inValid) begin
            state <= running;
        end
    end

    assign tableAddr = addrReg;
    assign outValid  = validLine[mixLatency-1];

    // Output strobe only after a sample was taken
    idleNoOutput: assert property (
        @(posedge clk) disable iff (!arstN)
        (state == idle) |-> !outValid
    ) else $error("outValid high while idle");

    // Control strobes are always driven
    strobesKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        !$isunknown({freqLoad, phaseClear, inValid})
    ) else $error("unknown control strobe");

endmodule : mixerControl

`default_nettype wire

// ==== rtl/ncoPkg.sv ====
// Oscillator and pipeline constants
`default_nettype none

package ncoPkg;

    // Phase accumulator width
    localparam int phaseWidth = 24;

    // Phase word, one full turn wraps to zero
    typedef logic [phaseWidth-1:0] phaseT;

    // Top phase bits, quadrant in [7:6] and index in [5:0]
    typedef logic [7:0] tableAddrT;

    // Quarter wave from 0 to 90 degrees inclusive
    localparam int quarterDepth = 65;

    // Hex image of the first sine quadrant
    localparam string quarterFile = "quarterSine.mem";

    // Cycles from inValid to outValid
    localparam int mixLatency = 3;

endpackage : ncoPkg

`default_nettype wire

// ==== rtl/quarterSine.mem ====
// One column: T[k] = round(131071 * sin(k * pi / 128)), k = 0 to 64, 18-bit hex
00000
00c91
0191f
025aa
0322f
03eac
04b20
05788
063e3
0702e
07c68
0888e
094a0
0a09b
0ac7c
0b844
0c3ef
0cf7b
0dae8
0e633
0f15a
0fc5d
10738
111eb
11c73
126d0
130ff
13aff
144cf
14e6c
157d6
1610b
16a09
172d0
17b5d
183b0
18bc7
193a1
19b3d
1a29a
1a9b6
1b090
1b727
1bd7b
1c38a
1c954
1ced7
1d412
1d906
1ddb0
1e211
1e628
1e9f3
1ed73
1f0a7
1f38e
1f629
1f875
1fa74
1fc25
1fd88
1fe9c
1ff61
1ffd8
1ffff

// ==== rtl/sinCosTable.sv ====
// Quarter-wave cosine and sine lookup
`default_nettype none

module sinCosTable
    import dspTypesPkg::*;
    import ncoPkg::*;
(
    input  wire tableAddrT tableAddr,
    output sampleT         cosVal,
    output sampleT         sinVal
);

    // Most negative sample, never produced by the fold
    localparam sampleT negFullScale = 18'sh20000;

    // First sine quadrant, T[0] = 0 up to T[64] = full scale
    sampleT quarterRom [0:quarterDepth-1];

    initial begin
        $readmemh(quarterFile, quarterRom);
    end

    // Quadrant select and position within it
    logic [1:0] quadrant;
    logic [6:0] index;
    // Mirrored position, 64 - index
    logic [6:0] mirror;

    // Table reads at both ends of the quadrant
    sampleT fwdVal;
    sampleT revVal;

    assign quadrant = tableAddr[7:6];
    assign index    = {1'b0, tableAddr[5:0]};
    assign mirror   = 7'(quarterDepth - 1) - index;

    assign fwdVal = quarterRom[index];
    assign revVal = quarterRom[mirror];

    // Quadrant fold
    always_comb begin
        unique case (quadrant)
            2'd0: begin
                sinVal = fwdVal;
                cosVal = revVal;
            end
            2'd1: begin
                sinVal = revVal;
                cosVal = -fwdVal;
            end
            2'd2: begin
                sinVal = -fwdVal;
                cosVal = -revVal;
            end
            default: begin
                // Fourth quadrant
                sinVal = -revVal;
                cosVal = fwdVal;
            end
        endcase
    end

    // Table contents must stay within the symmetric range
    always_comb begin
        assert (cosVal != negFullScale && sinVal != negFullScale)
        else $error("table value at negative full scale");
    end

endmodule : sinCosTable

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run from rtl/ so the table file is found
verilator --binary --timing -f filelist.f --top-module mixerTb -o mixerSim \
    && (cd rtl && ../obj_dir/mixerSim) | tee /dev/stderr | grep -q "\*\*\* TEST PASSED \*\*\*" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== test/mixerTb.sv ====
// Digital mixer testbench
`default_nettype none

module mixerTb
    import dspTypesPkg::*;
    import ncoPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clkPeriod   = 40;
    localparam int resetCycles = 2;
    localparam int driveDelay  = 2;
    localparam int randCount   = 200;
    localparam int gapCount    = 120;
    // Rough cycle budget of all test phases
    localparam int stimCycles  = resetCycles + 16 + randCount + 24 + 40 + 24 + gapCount + 40;
    localparam int marginCycles = 200;

    logic   clk;
    logic   arstN;
    logic   inValid;
    sampleT inReal;
    sampleT inImag;
    logic   freqLoad;
    phaseT  freqWord;
    logic   phaseClear;
    logic   outValid;
    sampleT outReal;
    sampleT outImag;

    // Stimulus LFSR
    logic [15:0] lfsrState;

    // Model oscillator
    phaseT modelPhase;
    phaseT modelFreq;

    // Expected outputs in issue order
    sampleT expReQ[$];
    sampleT expImQ[$];

    int mismatchCount;
    int timingCount;

    // Input strobes seen at the last three edges
    logic [mixLatency-1:0] validHist;

    // Own copy of the quarter table
    sampleT refRom [0:quarterDepth-1];

    digitalMixer dut (
        .clk        (clk),
        .arstN      (arstN),
        .inValid    (inValid),
        .inReal     (inReal),
        .inImag     (inImag),
        .freqLoad   (freqLoad),
        .freqWord   (freqWord),
        .phaseClear (phaseClear),
        .outValid   (outValid),
        .outReal    (outReal),
        .outImag    (outImag)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // One Fibonacci step with taps 16 14 13 11
    function automatic logic nextLfsrBit();
        logic fb;
        fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], fb};
        return fb;
    endfunction

    // n fresh bits with one step each
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], nextLfsrBit()};
        end
        return r;
    endfunction

    // Quadrant fold of the quarter table
    function automatic void foldTable(input tableAddrT addr, output sampleT c,
                                      output sampleT s);
        int i;
        sampleT fwd;
        sampleT rev;
        i = int'(addr[5:0]);
        fwd = refRom[i];
        rev = refRom[64 - i];
        case (addr[7:6])
            2'd0: begin
                s = fwd;
                c = rev;
            end
            2'd1: begin
                s = rev;
                c = -fwd;
            end
            2'd2: begin
                s = -fwd;
                c = -rev;
            end
            default: begin
                s = -rev;
                c = fwd;
            end
        endcase
    endfunction

    // Clamp outside +-2^34 or take the floor of sum / 2^17
    function automatic sampleT saturateRef(input longint sum);
        if (sum >= (longint'(1) << 34)) begin
            return 18'sh1ffff;
        end
        if (sum < -(longint'(1) << 34)) begin
            return 18'sh20001;
        end
        return sampleT'(sum >>> 17);
    endfunction

    // Expected mixer output for one sample
    function automatic void mixRef(input sampleT re, input sampleT im, input tableAddrT addr,
                                   output sampleT yRe, output sampleT yIm);
        sampleT c;
        sampleT s;
        longint sumRe;
        longint sumIm;
        foldTable(addr, c, s);
        sumRe = longint'(re) * longint'(c) - longint'(im) * longint'(s);
        sumIm = longint'(re) * longint'(s) + longint'(im) * longint'(c);
        yRe = saturateRef(sumRe);
        yIm = saturateRef(sumIm);
    endfunction

    // One cycle of inputs with the model updated in step
    task automatic driveCycle(input logic v, input sampleT re, input sampleT im,
                              input logic load, input phaseT word, input logic clr);
        sampleT yRe;
        sampleT yIm;
        @(posedge clk);
        #(driveDelay);
        inValid    = v;
        inReal     = re;
        inImag     = im;
        freqLoad   = load;
        freqWord   = word;
        phaseClear = clr;
        // Sample sees the phase before this edge's update
        if (v) begin
            mixRef(re, im, modelPhase[phaseWidth-1 -: 8], yRe, yIm);
            expReQ.push_back(yRe);
            expImQ.push_back(yIm);
        end
        if (clr) begin
            modelPhase = '0;
        end else if (v) begin
            modelPhase = modelPhase + modelFreq;
        end
        // New word only counts from the next increment
        if (load) begin
            modelFreq = word;
        end
    endtask

    task automatic sendSample(input sampleT re, input sampleT im);
        driveCycle(1'b1, re, im, 1'b0, '0, 1'b0);
    endtask

    task automatic idleCycle();
        driveCycle(1'b0, '0, '0, 1'b0, '0, 1'b0);
    endtask

    task automatic randomSample();
        sampleT re;
        sampleT im;
        re = sampleT'(randomBits(18));
        im = sampleT'(randomBits(18));
        sendSample(re, im);
    endtask

    // Strobe or control with a random sample
    task automatic randomControl(input logic v, input logic load, input logic clr);
        sampleT re;
        sampleT im;
        phaseT word;
        re = sampleT'(randomBits(18));
        im = sampleT'(randomBits(18));
        word = phaseT'(randomBits(24));
        driveCycle(v, re, im, load, word, clr);
    endtask

    // Four full-scale corners at the current phase
    task automatic fullScaleSet();
        sendSample(18'sh1ffff, 18'sh1ffff);
        sendSample(18'sh20000, 18'sh20000);
        sendSample(18'sh1ffff, 18'sh20000);
        sendSample(18'sh20000, 18'sh1ffff);
    endtask

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validHist <= '0;
        end else begin
            validHist <= {validHist[mixLatency-2:0], inValid};
        end
    end

    // Compare at the falling edge away from the drive point
    always @(negedge clk) begin
        sampleT expRe;
        sampleT expIm;
        if (arstN) begin
            assert (outValid === validHist[mixLatency-1])
            else begin
                $display("MISMATCH outValid got %h expected %h at %0t",
                         outValid, validHist[mixLatency-1], $time);
                timingCount++;
            end
            if (outValid) begin
                assert (expReQ.size() != 0)
                else begin
                    $display("Output strobe at %0t with no sample waiting", $time);
                    timingCount++;
                end
                if (expReQ.size() != 0) begin
                    expRe = expReQ.pop_front();
                    expIm = expImQ.pop_front();
                    assert (outReal === expRe)
                    else begin
                        $display("MISMATCH outReal got %h expected %h", outReal, expRe);
                        mismatchCount++;
                    end
                    assert (outImag === expIm)
                    else begin
                        $display("MISMATCH outImag got %h expected %h", outImag, expIm);
                        mismatchCount++;
                    end
                end
            end
        end
    end

    initial begin
        arstN      = 1'b0;
        inValid    = 1'b0;
        inReal     = '0;
        inImag     = '0;
        freqLoad   = 1'b0;
        freqWord   = '0;
        phaseClear = 1'b0;
        lfsrState  = 16'd63839;
        modelPhase = '0;
        modelFreq  = '0;
        mismatchCount = 0;
        timingCount   = 0;
        $readmemh(quarterFile, refRom);
        repeat (resetCycles) @(posedge clk);
        #(driveDelay);
        arstN = 1'b1;

        // Zero word, cleared phase, cosine at full scale
        driveCycle(1'b0, '0, '0, 1'b0, '0, 1'b1);
        repeat (8) randomSample();
        sendSample(18'sh1ffff, 18'sh20000);

        // Random word, back-to-back strobes
        randomControl(1'b0, 1'b1, 1'b0);
        repeat (randCount) randomSample();

        // Park the phase at 45 degrees
        driveCycle(1'b0, '0, '0, 1'b1, 24'h200000, 1'b1);
        sendSample('0, '0);
        driveCycle(1'b0, '0, '0, 1'b1, 24'h000000, 1'b0);
        fullScaleSet();
        // Then at 135 degrees
        driveCycle(1'b0, '0, '0, 1'b1, 24'h400000, 1'b0);
        sendSample('0, '0);
        driveCycle(1'b0, '0, '0, 1'b1, 24'h000000, 1'b0);
        fullScaleSet();

        // Word changes mid-stream with one alongside a sample
        randomControl(1'b0, 1'b1, 1'b0);
        repeat (10) randomSample();
        randomControl(1'b1, 1'b1, 1'b0);
        repeat (10) randomSample();
        randomControl(1'b0, 1'b1, 1'b0);
        repeat (10) randomSample();

        // Phase clear alone and then with a sample
        repeat (6) randomSample();
        randomControl(1'b0, 1'b0, 1'b1);
        repeat (6) randomSample();
        randomControl(1'b1, 1'b0, 1'b1);
        repeat (6) randomSample();

        // Gapped strobes
        repeat (gapCount) randomControl(nextLfsrBit(), 1'b0, 1'b0);
        repeat (6) idleCycle();

        while (expReQ.size() != 0) @(posedge clk);
        repeat (8) @(posedge clk);

        $display("Errors: %0d mismatches, %0d strobe failures", mismatchCount, timingCount);
        if (mismatchCount == 0 && timingCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Run limit from the stimulus length
    initial begin
        #((stimCycles + marginCycles) * clkPeriod);
        $display("Watchdog expired with %0d samples still expected", expReQ.size());
        $display("Errors: %0d mismatches, %0d strobe failures", mismatchCount, timingCount);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule : mixerTb

`default_nettype wire
